//--- hw/cpu_pkg.sv
/* widths, opcodes, ALU selects, memory request/response structs,
   micro-step enum and datapath control word for the accumulator CPU */

package cpu_pkg;

   // ******************************
   // sizes
   // ******************************

   localparam int DATA_W    = 8;
   localparam int ADDR_W    = 8;
   localparam int RAM_DEPTH = 256;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // ******************************
   // instruction set
   // ******************************

   // the low three bits of the ALU opcodes equal the ALU select
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_SUB1 = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_XNOR = 4'd6,
      OP_LDA  = 4'd7,
      OP_STA  = 4'd8,
      OP_JZ   = 4'd9,
      OP_JC   = 4'd10,
      OP_JMP  = 4'd11,
      OP_CLC  = 4'd12,
      OP_HALT = 4'd13
   } opcode_t;

   // code 7 is not used and makes the ALU return zero
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_SUB1 = 3'd2,
      ALU_AND  = 3'd3,
      ALU_OR   = 3'd4,
      ALU_XOR  = 3'd5,
      ALU_XNOR = 3'd6
   } alu_sel_t;

   // ******************************
   // memory port
   // ******************************

   typedef struct packed {
      logic  valid;
      logic  write;
      addr_t addr;
      data_t wdata;
   } mem_req_t;

   // read data qualified by a one-cycle valid, there is no ready
   typedef struct packed {
      logic  valid;
      data_t rdata;
   } mem_rsp_t;

   // ******************************
   // control
   // ******************************

   typedef enum logic [3:0] {
      US_IDLE, US_FETCH_OP, US_WAIT_OP, US_FETCH_ARG, US_WAIT_ARG,
      US_READ_DATA, US_WAIT_DATA, US_EXEC, US_STORE, US_HALTED
   } ustep_t;

   // pc_jump together with pc_inc selects the restart vector, address 0
   typedef struct packed {
      logic ir_load;
      logic arg_load;
      logic acc_from_alu;
      logic acc_from_mem;
      logic pc_inc;
      logic pc_jump;
      logic carry_clear;
      logic flags_load;
   } uctrl_t;

endpackage

//--- hw/alu.sv
/* combinational 8-bit ALU with carry and zero outputs */

`timescale 1ns/100ps

module alu
   import cpu_pkg::*;
(
   input  data_t    a,
   input  data_t    b,
   input  logic     cin,
   input  alu_sel_t select,
   output data_t    result,
   output logic     carry,
   output logic     zero
);

   // nine bits wide so the top bit comes out as carry
   logic [DATA_W:0] full;
   logic [DATA_W:0] cin_ext;

   assign cin_ext = {{DATA_W{1'b0}}, cin};

   // ******************************
   // function decode
   // ******************************

   always_comb
   begin
      case (select)
         ALU_ADD:
            full = {1'b0, a} + {1'b0, b} + cin_ext;
         // a minus b, where cin high cancels the extra borrow
         ALU_SUB:
            full = {1'b0, a} - {1'b0, b} - 1'b1 + cin_ext;
         // reverse subtract, b minus a
         ALU_SUB1:
            full = {1'b0, b} - {1'b0, a} - 1'b1 + cin_ext;
         // the logic ops never produce a carry
         ALU_AND:
            full = {1'b0, a & b};
         ALU_OR:
            full = {1'b0, a | b};
         ALU_XOR:
            full = {1'b0, a ^ b};
         ALU_XNOR:
            full = {1'b0, a ~^ b};
         default:
            full = '0;
      endcase
   end

   assign result = full[DATA_W-1:0];
   assign carry  = full[DATA_W];

   // zero looks at the byte result only, not at the carry
   assign zero = (result == '0);

   // an unknown select would silently pick the default branch
   always_comb
   begin
      assert (!$isunknown(select))
         else $error("alu select is unknown");
   end

endmodule

//--- hw/micro_sequencer.sv
/* microcode ROM and micro-step FSM issuing datapath controls
   and the CPU memory requests */

`timescale 1ns/100ps

module micro_sequencer
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   input  opcode_t  opcode,
   input  logic     zero_flag,
   input  logic     carry_flag,
   input  addr_t    pc,
   input  data_t    acc,
   input  data_t    arg,
   input  logic     cpu_ready,
   input  mem_rsp_t cpu_rsp,
   output mem_req_t cpu_req,
   output uctrl_t   ctrl,
   output logic     halted
);

   // steps an instruction needs once both of its bytes are in
   typedef struct packed {
      logic rd;    // read the operand byte at arg
      logic st;    // write acc to arg
   } urom_t;

   ustep_t state;
   ustep_t state_nxt;
   urom_t  uword;

   // ******************************
   // microcode ROM
   // ******************************

   always_comb
   begin
      case (opcode)
         OP_ADD, OP_SUB, OP_SUB1, OP_AND, OP_OR, OP_XOR, OP_XNOR, OP_LDA:
            uword = '{rd: 1'b1, st: 1'b0};
         OP_STA:
            uword = '{rd: 1'b0, st: 1'b1};
         // branches, CLC, HALT and unused codes all end in execute
         default:
            uword = '{rd: 1'b0, st: 1'b0};
      endcase
   end

   // ******************************
   // step register
   // ******************************

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= US_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      ctrl      = '0;
      cpu_req   = '0;
      case (state)
         US_IDLE, US_HALTED:
         begin
            // a start sends pc back to 0 and begins fetch
            if (start)
            begin
               ctrl.pc_jump = 1'b1;
               ctrl.pc_inc  = 1'b1;
               state_nxt    = US_FETCH_OP;
            end
         end
         US_FETCH_OP:
         begin
            cpu_req.valid = 1'b1;
            cpu_req.addr  = pc;
            // pc only moves on transfer so the address stays stable
            if (cpu_ready)
            begin
               ctrl.pc_inc = 1'b1;
               state_nxt   = US_WAIT_OP;
            end
         end
         US_WAIT_OP:
         begin
            if (cpu_rsp.valid)
            begin
               ctrl.ir_load = 1'b1;
               state_nxt    = US_FETCH_ARG;
            end
         end
         US_FETCH_ARG:
         begin
            cpu_req.valid = 1'b1;
            cpu_req.addr  = pc;
            if (cpu_ready)
            begin
               ctrl.pc_inc = 1'b1;
               state_nxt   = US_WAIT_ARG;
            end
         end
         US_WAIT_ARG:
         begin
            if (cpu_rsp.valid)
            begin
               ctrl.arg_load = 1'b1;
               if (uword.rd)
                  state_nxt = US_READ_DATA;
               else if (uword.st)
                  state_nxt = US_STORE;
               else
                  state_nxt = US_EXEC;
            end
         end
         US_READ_DATA:
         begin
            cpu_req.valid = 1'b1;
            cpu_req.addr  = arg;
            if (cpu_ready)
               state_nxt = US_WAIT_DATA;
         end
         US_WAIT_DATA:
         begin
            // the operand byte is only on the bus this cycle, so capture now
            if (cpu_rsp.valid)
            begin
               if (opcode == OP_LDA)
                  ctrl.acc_from_mem = 1'b1;
               else
               begin
                  ctrl.acc_from_alu = 1'b1;
                  ctrl.flags_load   = 1'b1;
               end
               state_nxt = US_FETCH_OP;
            end
         end
         US_EXEC:
         begin
            state_nxt = US_FETCH_OP;
            case (opcode)
               OP_JMP:  ctrl.pc_jump     = 1'b1;
               OP_JZ:   ctrl.pc_jump     = zero_flag;
               OP_JC:   ctrl.pc_jump     = carry_flag;
               OP_CLC:  ctrl.carry_clear = 1'b1;
               OP_HALT: state_nxt        = US_HALTED;
               default: ;
            endcase
         end
         US_STORE:
         begin
            cpu_req.valid = 1'b1;
            cpu_req.write = 1'b1;
            cpu_req.addr  = arg;
            cpu_req.wdata = acc;
            if (cpu_ready)
               state_nxt = US_FETCH_OP;
         end
         default:
            state_nxt = US_IDLE;
      endcase
   end

   assign halted = (state == US_HALTED);

   // a request under back-pressure must stay as it is until the arbiter takes it
   req_held: assert property (@(posedge clk) disable iff (reset)
      cpu_req.valid && !cpu_ready |=> cpu_req.valid && $stable(cpu_req))
      else $error("cpu request changed before ready");

   // the arbiter only returns data for reads this FSM issued
   rsp_in_wait: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp.valid |-> state inside {US_WAIT_OP, US_WAIT_ARG, US_WAIT_DATA})
      else $error("cpu response outside a wait step");

endmodule

//--- hw/cpu_datapath.sv
/* accumulator, flags, program counter, instruction and operand
   registers around the ALU */

`timescale 1ns/100ps

module cpu_datapath
   import cpu_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  uctrl_t  ctrl,
   input  data_t   mem_rdata,
   output opcode_t opcode,
   output addr_t   pc,
   output data_t   acc,
   output data_t   arg,
   output logic    zero_flag,
   output logic    carry_flag
);

   opcode_t  ir;
   alu_sel_t alu_select;
   data_t    alu_result;
   logic     alu_carry;
   logic     alu_zero;

   // ******************************
   // ALU
   // ******************************

   // ALU opcodes carry their select in the low three bits
   assign alu_select = alu_sel_t'(ir[2:0]);

   alu u_alu (
      .a      (acc),
      .b      (mem_rdata),
      .cin    (carry_flag),
      .select (alu_select),
      .result (alu_result),
      .carry  (alu_carry),
      .zero   (alu_zero)
   );

   // ******************************
   // registers
   // ******************************

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ir         <= OP_ADD;
         pc         <= '0;
         acc        <= '0;
         zero_flag  <= 1'b0;
         carry_flag <= 1'b0;
      end
      else
      begin
         // opcode sits in the upper nibble of the first byte
         if (ctrl.ir_load)
            ir <= opcode_t'(mem_rdata[7:4]);
         // jump and increment together is the restart request
         if (ctrl.pc_jump && ctrl.pc_inc)
            pc <= '0;
         else if (ctrl.pc_jump)
            pc <= arg;
         else if (ctrl.pc_inc)
            pc <= pc + 1'b1;
         if (ctrl.acc_from_alu)
            acc <= alu_result;
         else if (ctrl.acc_from_mem)
         begin
            acc       <= mem_rdata;
            zero_flag <= (mem_rdata == '0);
         end
         if (ctrl.flags_load)
            zero_flag <= alu_zero;
         if (ctrl.carry_clear)
            carry_flag <= 1'b0;
         else if (ctrl.flags_load)
            carry_flag <= alu_carry;
      end
   end

   // the operand register holds the address byte of the current instruction
   always_ff @(posedge clk)
   begin
      if (ctrl.arg_load)
         arg <= mem_rdata;
   end

   assign opcode = ir;

endmodule

//--- hw/mem_arbiter.sv
/* round-robin arbiter between host and CPU, steering read data
   back to the requester that issued the read */

`timescale 1ns/100ps

module mem_arbiter
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  mem_req_t host_req,
   output logic     host_ready,
   output mem_rsp_t host_rsp,
   input  mem_req_t cpu_req,
   output logic     cpu_ready,
   output mem_rsp_t cpu_rsp,
   output mem_req_t ram_req,
   input  data_t    ram_rdata
);

   logic prio_host;
   logic rd_pend;
   logic owner_cpu;
   logic grant_host;
   logic grant_cpu;

   // ******************************
   // grant
   // ******************************

   assign grant_host = host_req.valid && (!cpu_req.valid || prio_host);
   assign grant_cpu  = cpu_req.valid && (!host_req.valid || !prio_host);

   assign host_ready = grant_host;
   assign cpu_ready  = grant_cpu;

   always_comb
   begin
      if (grant_host)
         ram_req = host_req;
      else if (grant_cpu)
         ram_req = cpu_req;
      else
         ram_req = '0;
   end

   // priority passes to the other side after every grant and starts with the host
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prio_host <= 1'b1;
         rd_pend   <= 1'b0;
      end
      else
      begin
         if (grant_host)
            prio_host <= 1'b0;
         else if (grant_cpu)
            prio_host <= 1'b1;
         rd_pend <= ram_req.valid && !ram_req.write;
      end
   end

   // owner_cpu names the requester of the read in flight and matters only while rd_pend is high
   always_ff @(posedge clk)
   begin
      owner_cpu <= grant_cpu;
   end

   // the RAM answers one cycle later and only the owner sees the data
   assign host_rsp.valid = rd_pend && !owner_cpu;
   assign host_rsp.rdata = host_rsp.valid ? ram_rdata : '0;
   assign cpu_rsp.valid  = rd_pend && owner_cpu;
   assign cpu_rsp.rdata  = cpu_rsp.valid ? ram_rdata : '0;

   // with both sides waiting, a grant hands the next slot to the other side
   host_then_cpu: assert property (@(posedge clk) disable iff (reset)
      host_ready && cpu_req.valid |=> !host_req.valid || !cpu_req.valid || cpu_ready)
      else $error("cpu not granted after a host grant under contention");

   cpu_then_host: assert property (@(posedge clk) disable iff (reset)
      cpu_ready && host_req.valid |=> !host_req.valid || !cpu_req.valid || host_ready)
      else $error("host not granted after a cpu grant under contention");

endmodule

//--- hw/data_ram.sv
/* single-port 256x8 RAM with synchronous write and registered read */

`timescale 1ns/100ps

module data_ram
   import cpu_pkg::*;
(
   input  logic     clk,
   input  mem_req_t ram_req,
   output data_t    ram_rdata
);

   data_t mem [RAM_DEPTH];

   // ******************************
   // access
   // ******************************

   // writes land at the transfer edge
   always_ff @(posedge clk)
   begin
      if (ram_req.valid && ram_req.write)
         mem[ram_req.addr] <= ram_req.wdata;
   end

   // read data appears the cycle after the transfer and holds until the next read
   always_ff @(posedge clk)
   begin
      if (ram_req.valid && !ram_req.write)
         ram_rdata <= mem[ram_req.addr];
   end

endmodule

//--- hw/cpu_top.sv
/* CPU top level joining sequencer, datapath, arbiter and RAM
   with the host port */

`timescale 1ns/100ps

module cpu_top
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   input  mem_req_t host_req,
   output logic     host_ready,
   output mem_rsp_t host_rsp,
   output logic     halted
);

   // ******************************
   // internal nets
   // ******************************

   uctrl_t   ctrl;
   opcode_t  opcode;
   addr_t    pc;
   data_t    acc;
   data_t    arg;
   logic     zero_flag;
   logic     carry_flag;
   mem_req_t cpu_req;
   logic     cpu_ready;
   mem_rsp_t cpu_rsp;
   mem_req_t ram_req;
   data_t    ram_rdata;

   micro_sequencer u_seq (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .opcode     (opcode),
      .zero_flag  (zero_flag),
      .carry_flag (carry_flag),
      .pc         (pc),
      .acc        (acc),
      .arg        (arg),
      .cpu_ready  (cpu_ready),
      .cpu_rsp    (cpu_rsp),
      .cpu_req    (cpu_req),
      .ctrl       (ctrl),
      .halted     (halted)
   );

   // the datapath sees the CPU read data, ctrl decides which register takes it
   cpu_datapath u_dp (
      .clk        (clk),
      .reset      (reset),
      .ctrl       (ctrl),
      .mem_rdata  (cpu_rsp.rdata),
      .opcode     (opcode),
      .pc         (pc),
      .acc        (acc),
      .arg        (arg),
      .zero_flag  (zero_flag),
      .carry_flag (carry_flag)
   );

   mem_arbiter u_arb (
      .clk        (clk),
      .reset      (reset),
      .host_req   (host_req),
      .host_ready (host_ready),
      .host_rsp   (host_rsp),
      .cpu_req    (cpu_req),
      .cpu_ready  (cpu_ready),
      .cpu_rsp    (cpu_rsp),
      .ram_req    (ram_req),
      .ram_rdata  (ram_rdata)
   );

   data_ram u_ram (
      .clk       (clk),
      .ram_req   (ram_req),
      .ram_rdata (ram_rdata)
   );

endmodule

//--- verif/cpu_tb.sv
/* trace-driven testbench for the accumulator CPU with clock, reset,
   host port driver, readback checker and watchdog */

`timescale 1ns/100ps

module cpu_tb
   import cpu_pkg::*;
();

   // cycles the watchdog allows for each line of the trace
   localparam int CYCLES_PER_LINE = 200;

   logic     clk;
   logic     reset;
   logic     start;
   mem_req_t host_req;
   logic     host_ready;
   mem_rsp_t host_rsp;
   logic     halted;

   int              trace_lines;
   integer          seed;
   logic [8*32-1:0] test_name;

   cpu_top UUT (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .host_req   (host_req),
      .host_ready (host_ready),
      .host_rsp   (host_rsp),
      .halted     (halted)
   );

   // ******************************
   // clock and watchdog
   // ******************************

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // starts once the trace has been counted
   initial
   begin
      wait (trace_lines > 0);
      repeat (trace_lines * CYCLES_PER_LINE) @(posedge clk);
      $display("timeout, the trace did not finish within %0d cycles",
               trace_lines * CYCLES_PER_LINE);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   // ******************************
   // host port driver
   // ******************************

   // one host transfer, a read hands back the byte seen on host_rsp
   task automatic host_transfer(input logic wr, input addr_t addr, input data_t wdata,
                                output data_t rdata);
      @(posedge clk);
      host_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
      // ready is combinational, so it is settled in the middle of the cycle
      do
         @(negedge clk);
      while (!host_ready);
      // the transfer happens at this edge
      @(posedge clk);
      host_req <= '0;
      rdata = '0;
      if (!wr)
      begin
         // the response must show up in the very next cycle
         @(negedge clk);
         assert (host_rsp.valid)
         else
         begin
            $display("no read response one cycle after the read of address %02h in test %0s",
                     addr, test_name);
            $display("Simulation failed");
            $fatal(1, "missing read response");
         end
         rdata = host_rsp.rdata;
      end
   endtask

   // random pause of 0 to 3 cycles before a host request
   task automatic idle_gap();
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
   endtask

   task automatic write_byte(input addr_t addr, input data_t data);
      data_t unused;
      idle_gap();
      host_transfer(1'b1, addr, data, unused);
   endtask

   task automatic check_read(input addr_t addr, input data_t expected);
      data_t actual;
      idle_gap();
      host_transfer(1'b0, addr, '0, actual);
      assert (actual === expected)
      else
      begin
         $display("** Error test %0s: address %02h expected %02h actual %02h",
                  test_name, addr, expected, actual);
         $display("Simulation failed");
         $fatal(1, "readback mismatch");
      end
   endtask

   // one-cycle start pulse, the sequencer leaves IDLE or HALTED at the second edge
   task automatic start_pulse();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_halted();
      do
         @(negedge clk);
      while (!halted);
   endtask

   // ******************************
   // trace player
   // ******************************

   initial
   begin
      integer           fd;
      integer           code;
      int               count;
      logic [8*32-1:0]  tok;
      logic [8*160-1:0] line;
      addr_t            addr;
      data_t            data;
      logic             done;

      reset    <= 1'b1;
      start    <= 1'b0;
      host_req <= '0;
      seed      = 32'hd4d6;
      test_name = "none";

      // the watchdog budget follows from the length of the trace
      fd = $fopen("verif/cpu_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file verif/cpu_trace.txt");
         $display("Simulation failed");
         $fatal(1, "no trace");
      end
      count = 0;
      while (!$feof(fd))
      begin
         if ($fgets(line, fd) != 0)
            count++;
      end
      $fclose(fd);
      trace_lines = count;

      repeat (5) @(posedge clk);
      reset <= 1'b0;

      fd   = $fopen("verif/cpu_trace.txt", "r");
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1)
            done = 1'b1;
         else if (tok == "#")
            code = $fgets(line, fd);
         else if (tok == "T")
         begin
            code = $fscanf(fd, "%s", test_name);
            $display("running test %0s", test_name);
         end
         else if (tok == "W")
         begin
            // a start address, a byte count and then the bytes
            code = $fscanf(fd, "%h %d", addr, count);
            for (int i = 0; i < count; i++)
            begin
               code = $fscanf(fd, "%h", data);
               write_byte(addr, data);
               addr++;
            end
         end
         else if (tok == "R")
         begin
            code = $fscanf(fd, "%h %h", addr, data);
            check_read(addr, data);
         end
         else if (tok == "S")
         begin
            start_pulse();
            wait_halted();
         end
         else if (tok == "G")
            start_pulse();
         else if (tok == "H")
            wait_halted();
         else
         begin
            $display("unknown command %0s in the trace during test %0s", tok, test_name);
            $display("Simulation failed");
            $fatal(1, "bad trace");
         end
      end
      $fclose(fd);

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- verif/cpu_trace.txt
# T name | W addr count bytes | R addr expected | S start and wait for halt | G start | H wait
# addresses and bytes in hex, counts in decimal, each instruction is opcode nibble then address
T host_rw
W 40 2 5a a5
W ff 1 3c
W 00 1 11
R 40 5a
R 41 a5
R ff 3c
R 00 11
T alu_ops
W 00 8 70 80 00 81 80 a0 00 84
W 08 8 80 a1 70 80 00 81 c0 00
W 10 8 00 84 80 a2 70 83 30 82
W 18 8 80 a3 70 83 40 80 80 a4
W 20 8 70 83 50 82 80 a5 70 83
W 28 8 60 82 80 a6 70 83 10 84
W 30 8 80 a7 70 84 20 81 80 a8
W 38 2 d0 00
W 80 5 f0 20 0f 33 01
S
R a0 10
R a1 12
R a2 11
R a3 03
R a4 f3
R a5 3c
R a6 c3
R a7 31
R a8 1e
T borrow
W 00 8 c0 00 70 90 10 91 80 b0
W 08 8 a0 0c d0 00 70 92 80 b1
W 10 8 c0 00 70 90 20 91 80 b2
W 18 8 a0 1e 70 93 80 b3 d0 00
W 90 4 05 07 ff 00
W b0 4 00 00 00 aa
S
R b0 fd
R b1 ff
R b2 01
R b3 00
T zero_loop
W 00 8 c0 00 70 98 10 9b 80 98
W 08 8 70 9a 00 99 80 9a 70 98
W 10 6 90 14 b0 02 d0 00
W 98 4 03 01 00 00
S
R 98 00
R 9a 03
T arbitration
W e0 4 11 22 33 44
W 98 1 08
W 9a 1 00
G
R e0 11
R e1 22
R e2 33
R e3 44
R e3 44
R e2 33
R e1 22
R e0 11
H
R 98 00
R 9a 08
T restart
W 98 1 05
W 9a 1 10
S
R 98 00
R 9a 15

//--- vlog.f
hw/cpu_pkg.sv
hw/alu.sv
hw/micro_sequencer.sv
hw/cpu_datapath.sv
hw/mem_arbiter.sv
hw/data_ram.sv
hw/cpu_top.sv
verif/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the CPU testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module cpu_tb -f vlog.f -o cpu_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation run exited with status $status"
   exit $status
fi

exit 0
